// ==== rnd_pkg.sv ====
// single-precision format only; flag vector is 8 bits with no divide-by-zero flag
package rnd_pkg;

  ////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////

  typedef logic [27:0] fract28_t;  // carry, 24 mantissa bits, round, sticky
  typedef logic [31:0] fract32_t;  // i2f fraction, aligned stage-1 fraction
  typedef logic [34:0] fract35_t;  // 32 bits plus 3 guard positions
  typedef logic [9:0]  exp10_t;    // biased exponent, 2 extra bits for ovf/unf
  typedef logic [7:0]  exp8_t;     // i2f exponent candidates
  typedef logic [4:0]  shamt_t;    // align shift amount
  typedef logic [31:0] float32_t;  // packed sign/exp/mantissa
  typedef logic [7:0]  fpflags_t;  // exception flags

  // rounding modes, same encoding as the fpu control register
  typedef enum logic [1:0] {
    rm_nearest = 2'd0,
    rm_to_zero = 2'd1,
    rm_to_infp = 2'd2,
    rm_to_infm = 2'd3
  } rmode_e;

  ////////////////////////////////////////
  // flag bit positions
  ////////////////////////////////////////

  localparam int FLG_OVF = 0;  // overflow
  localparam int FLG_UNF = 1;  // underflow
  localparam int FLG_SNF = 2;  // signaling nan
  localparam int FLG_QNF = 3;  // quiet nan
  localparam int FLG_ZF  = 4;  // zero
  localparam int FLG_IXF = 5;  // inexact
  localparam int FLG_IVF = 6;  // invalid
  localparam int FLG_INF = 7;  // infinity

  // special magnitudes, sign goes in front
  localparam logic [30:0] INF_MAG  = 31'h7f80_0000;
  localparam logic [30:0] QNAN_MAG = 31'h7fc0_0000;
  localparam logic [30:0] SNAN_MAG = 31'h7fbf_ffff;

  localparam exp10_t EXP_MAX_NORMAL = 10'd254;  // anything above is overflow

endpackage

// ==== rnd_source_decode.sv ====
// ready strobes must be one-hot or idle; an idle cycle yields all-zero fields
module rnd_source_decode (
  input  rnd_pkg::rmode_e   rmode_i,
  // add/sub source
  input  logic              add_rdy_i,
  input  logic              add_sign_i,
  input  logic              add_sub_0_i,     // exact cancellation
  input  rnd_pkg::shamt_t   add_shl_i,
  input  rnd_pkg::exp10_t   add_exp10shl_i,
  input  rnd_pkg::exp10_t   add_exp10sh0_i,
  input  rnd_pkg::fract28_t add_fract28_i,
  input  logic              add_inv_i,
  input  logic              add_inf_i,
  input  logic              add_snan_i,
  input  logic              add_qnan_i,
  input  logic              add_anan_sign_i,
  // mul source
  input  logic              mul_rdy_i,
  input  logic              mul_sign_i,
  input  rnd_pkg::shamt_t   mul_shr_i,
  input  rnd_pkg::exp10_t   mul_exp10shr_i,
  input  logic              mul_shl_i,       // mul needs at most one bit left
  input  rnd_pkg::exp10_t   mul_exp10shl_i,
  input  rnd_pkg::exp10_t   mul_exp10sh0_i,
  input  rnd_pkg::fract28_t mul_fract28_i,
  input  logic              mul_inv_i,
  input  logic              mul_inf_i,
  input  logic              mul_snan_i,
  input  logic              mul_qnan_i,
  input  logic              mul_anan_sign_i,
  // i2f source
  input  logic              i2f_rdy_i,
  input  logic              i2f_sign_i,
  input  logic [3:0]        i2f_shr_i,
  input  rnd_pkg::exp8_t    i2f_exp8shr_i,
  input  rnd_pkg::shamt_t   i2f_shl_i,
  input  rnd_pkg::exp8_t    i2f_exp8shl_i,
  input  rnd_pkg::exp8_t    i2f_exp8sh0_i,
  input  rnd_pkg::fract32_t i2f_fract32_i,
  // common field set
  output logic              sign_o,
  output logic              inv_o,
  output logic              inf_o,
  output logic              snan_o,
  output logic              qnan_o,
  output logic              anan_sign_o,
  output rnd_pkg::fract35_t fract_o,
  output rnd_pkg::shamt_t   shr_o,
  output rnd_pkg::shamt_t   shl_o,
  output logic              carry_o,
  output rnd_pkg::exp10_t   exp_shr_o,
  output rnd_pkg::exp10_t   exp_shl_o,
  output rnd_pkg::exp10_t   exp_sh0_o,
  output logic              any_rdy_o
);

  // exact x-x is +0, except -0 when rounding toward -inf
  logic add_sign;
  assign add_sign = add_sub_0_i ? (rmode_i == rnd_pkg::rm_to_infm) : add_sign_i;

  assign {sign_o, inv_o, inf_o, snan_o, qnan_o, anan_sign_o} =
    ({6{add_rdy_i}} & {add_sign, add_inv_i, add_inf_i, add_snan_i, add_qnan_i,
                       add_anan_sign_i}) |
    ({6{mul_rdy_i}} & {mul_sign_i, mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i,
                       mul_anan_sign_i}) |
    ({6{i2f_rdy_i}} & {i2f_sign_i, 5'd0});  // integers have no specials

  assign fract_o = ({35{add_rdy_i}} & {7'd0, add_fract28_i}) |
                   ({35{mul_rdy_i}} & {7'd0, mul_fract28_i}) |
                   ({35{i2f_rdy_i}} & {i2f_fract32_i, 3'd0});  // top aligned

  assign {shr_o, shl_o} = ({10{add_rdy_i}} & {5'd0, add_shl_i}) |  // add never shifts right
                          ({10{mul_rdy_i}} & {mul_shr_i, 4'd0, mul_shl_i}) |
                          ({10{i2f_rdy_i}} & {1'b0, i2f_shr_i, i2f_shl_i});

  assign carry_o = (add_rdy_i & add_fract28_i[27]) | (mul_rdy_i & mul_fract28_i[27]);

  // add reuses sh0 as its shr candidate
  assign {exp_shr_o, exp_shl_o, exp_sh0_o} =
    ({30{add_rdy_i}} & {add_exp10sh0_i, add_exp10shl_i, add_exp10sh0_i}) |
    ({30{mul_rdy_i}} & {mul_exp10shr_i, mul_exp10shl_i, mul_exp10sh0_i}) |
    ({30{i2f_rdy_i}} & {2'd0, i2f_exp8shr_i, 2'd0, i2f_exp8shl_i, 2'd0, i2f_exp8sh0_i});

  assign any_rdy_o = add_rdy_i | mul_rdy_i | i2f_rdy_i;

endmodule

// ==== rnd_align.sv ====
// stage 1; payload holds its last value when idle, only the valid bit is reset
module rnd_align (
  input  logic              clk,
  input  logic              rst,
  input  logic              adv_i,
  input  logic              flush_i,
  input  logic              sign_i,
  input  logic              inv_i,
  input  logic              inf_i,
  input  logic              snan_i,
  input  logic              qnan_i,
  input  logic              anan_sign_i,
  input  rnd_pkg::fract35_t fract_i,
  input  rnd_pkg::shamt_t   shr_i,
  input  rnd_pkg::shamt_t   shl_i,
  input  logic              carry_i,
  input  rnd_pkg::exp10_t   exp_shr_i,
  input  rnd_pkg::exp10_t   exp_shl_i,
  input  rnd_pkg::exp10_t   exp_sh0_i,
  input  logic              any_rdy_i,
  output logic              s1_sign_o,
  output rnd_pkg::exp10_t   s1_exp_o,
  output rnd_pkg::fract32_t s1_fract_o,
  output logic              s1_r_o,
  output logic              s1_s_o,
  output logic              s1_inv_o,
  output logic              s1_inf_o,
  output logic              s1_snan_o,
  output logic              s1_qnan_o,
  output logic              s1_anan_sign_o,
  output logic              s1_valid_o
);

  ////////////////////////////////////////
  // shift and sticky
  ////////////////////////////////////////

  rnd_pkg::shamt_t   shr_eff;
  logic              use_shr;
  rnd_pkg::fract35_t fract_sh;
  logic              sticky;
  rnd_pkg::exp10_t   exp_sel;

  // carry out of add/mul needs one bit right
  assign shr_eff  = (|shr_i) ? shr_i : {4'd0, carry_i};
  assign use_shr  = |shr_eff;
  assign fract_sh = use_shr ? (fract_i >> shr_eff) : (fract_i << shl_i);

  // sticky collects every bit landing below the round position (bit 2)
  always_comb begin
    sticky = 1'b0;
    for (int i = 0; i < 35; i++) begin
      if (use_shr) begin
        if (i < int'(shr_eff) + 2) sticky = sticky | fract_i[i];
      end else if (i + int'(shl_i) < 2) begin
        sticky = sticky | fract_i[i];  // left shift keeps fewer low bits
      end
    end
  end

  // exponent candidate follows the raw shift request
  assign exp_sel = (|shr_i) ? exp_shr_i :
                   (~|shl_i) ? exp_sh0_i + rnd_pkg::exp10_t'(carry_i) :
                   exp_shl_i;

  ////////////////////////////////////////
  // stage-1 register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_sign_o      <= sign_i;
      s1_exp_o       <= exp_sel;
      s1_fract_o     <= fract_sh[34:3];
      s1_r_o         <= fract_sh[2];
      s1_s_o         <= sticky;
      s1_inv_o       <= inv_i;
      s1_inf_o       <= inf_i;
      s1_snan_o      <= snan_i;
      s1_qnan_o      <= qnan_i;
      s1_anan_sign_o <= anan_sign_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid_o <= 1'b0;
    end else if (flush_i) begin
      s1_valid_o <= 1'b0;  // drop in-flight op
    end else if (adv_i) begin
      s1_valid_o <= any_rdy_i;
    end
  end

endmodule

// ==== rnd_round.sv ====
// purely combinational; expects a stage-1 fraction with the hidden bit at bit 23
module rnd_round (
  input  rnd_pkg::rmode_e   rmode_i,
  input  logic              s1_sign_i,
  input  rnd_pkg::exp10_t   s1_exp_i,
  input  rnd_pkg::fract32_t s1_fract_i,
  input  logic              s1_r_i,
  input  logic              s1_s_i,
  output logic [23:0]       fract24_o,  // mantissa with hidden bit
  output rnd_pkg::exp10_t   exp_o,
  output logic              lost_o
);

  logic              g;
  logic              rnd_up;
  rnd_pkg::fract32_t fract_rnd;
  logic              renorm;

  assign g      = s1_fract_i[0];  // guard is the mantissa lsb
  assign lost_o = s1_r_i | s1_s_i;

  // nearest-even: above half, or exactly half with odd lsb
  always_comb begin
    unique case (rmode_i)
      rnd_pkg::rm_nearest: rnd_up = s1_r_i & (s1_s_i | g);
      rnd_pkg::rm_to_zero: rnd_up = 1'b0;              // truncate
      rnd_pkg::rm_to_infp: rnd_up = ~s1_sign_i & lost_o;
      rnd_pkg::rm_to_infm: rnd_up = s1_sign_i & lost_o;
      default:             rnd_up = 1'b0;
    endcase
  end

  assign fract_rnd = s1_fract_i + rnd_pkg::fract32_t'(rnd_up);

  // all-ones mantissa rolled over into bit 24
  assign renorm    = fract_rnd[24];
  assign fract24_o = renorm ? fract_rnd[24:1] : fract_rnd[23:0];
  assign exp_o     = s1_exp_i + rnd_pkg::exp10_t'(renorm);

endmodule

// ==== rnd_result.sv ====
// stage 2; nan outranks invalid, which outranks overflow/inf, denormal and normal
module rnd_result (
  input  logic              clk,
  input  logic              rst,
  input  logic              adv_i,
  input  logic              flush_i,
  input  logic              s1_valid_i,
  input  logic              s1_sign_i,
  input  logic              s1_inv_i,
  input  logic              s1_inf_i,
  input  logic              s1_snan_i,
  input  logic              s1_qnan_i,
  input  logic              s1_anan_sign_i,
  input  logic [23:0]       fract24_i,
  input  rnd_pkg::exp10_t   exp_i,
  input  logic              lost_i,
  output rnd_pkg::float32_t result_o,
  output logic              valid_o,
  output rnd_pkg::fpflags_t flags_o
);

  rnd_pkg::float32_t res;
  rnd_pkg::fpflags_t flg;

  ////////////////////////////////////////
  // special-case priority
  ////////////////////////////////////////

  always_comb begin
    flg = '0;
    if (s1_snan_i | s1_qnan_i) begin
      res                    = {s1_anan_sign_i, rnd_pkg::QNAN_MAG};
      flg[rnd_pkg::FLG_QNF] = 1'b1;       // any nan input gives a quiet nan
      flg[rnd_pkg::FLG_IVF] = s1_snan_i;  // snan operand is invalid too
    end else if (s1_inv_i) begin
      res                    = {s1_sign_i, rnd_pkg::SNAN_MAG};
      flg[rnd_pkg::FLG_IVF] = 1'b1;
      flg[rnd_pkg::FLG_SNF] = 1'b1;
    end else if ((exp_i > rnd_pkg::EXP_MAX_NORMAL) | s1_inf_i) begin
      res                    = {s1_sign_i, rnd_pkg::INF_MAG};
      flg[rnd_pkg::FLG_OVF] = ~s1_inf_i;  // exact inf is no overflow
      flg[rnd_pkg::FLG_INF] = 1'b1;
      flg[rnd_pkg::FLG_IXF] = lost_i | ~s1_inf_i;
    end else if (~fract24_i[23]) begin
      // no hidden bit so the exponent field is 0
      res                    = {s1_sign_i, 8'd0, fract24_i[22:0]};
      flg[rnd_pkg::FLG_UNF] = lost_i;
      flg[rnd_pkg::FLG_ZF]  = ~|fract24_i;
      flg[rnd_pkg::FLG_IXF] = lost_i;
    end else begin
      res                    = {s1_sign_i, exp_i[7:0], fract24_i[22:0]};
      flg[rnd_pkg::FLG_IXF] = lost_i;
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      result_o <= '0;
      valid_o  <= 1'b0;
      flags_o  <= '0;
    end else if (flush_i) begin
      result_o <= '0;  // nothing of a flushed op leaks out
      valid_o  <= 1'b0;
      flags_o  <= '0;
    end else if (adv_i) begin
      result_o <= res;
      valid_o  <= s1_valid_i;
      flags_o  <= flg;
    end
  end

endmodule

// ==== rnd_top.sv ====
// two-stage back end; ready strobes one-hot, sampled only while adv_i is high
module rnd_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              adv_i,
  input  logic              flush_i,
  input  rnd_pkg::rmode_e   rmode_i,
  input  logic              add_rdy_i,
  input  logic              add_sign_i,
  input  logic              add_sub_0_i,
  input  rnd_pkg::shamt_t   add_shl_i,
  input  rnd_pkg::exp10_t   add_exp10shl_i,
  input  rnd_pkg::exp10_t   add_exp10sh0_i,
  input  rnd_pkg::fract28_t add_fract28_i,
  input  logic              add_inv_i,
  input  logic              add_inf_i,
  input  logic              add_snan_i,
  input  logic              add_qnan_i,
  input  logic              add_anan_sign_i,
  input  logic              mul_rdy_i,
  input  logic              mul_sign_i,
  input  rnd_pkg::shamt_t   mul_shr_i,
  input  rnd_pkg::exp10_t   mul_exp10shr_i,
  input  logic              mul_shl_i,
  input  rnd_pkg::exp10_t   mul_exp10shl_i,
  input  rnd_pkg::exp10_t   mul_exp10sh0_i,
  input  rnd_pkg::fract28_t mul_fract28_i,
  input  logic              mul_inv_i,
  input  logic              mul_inf_i,
  input  logic              mul_snan_i,
  input  logic              mul_qnan_i,
  input  logic              mul_anan_sign_i,
  input  logic              i2f_rdy_i,
  input  logic              i2f_sign_i,
  input  logic [3:0]        i2f_shr_i,
  input  rnd_pkg::exp8_t    i2f_exp8shr_i,
  input  rnd_pkg::shamt_t   i2f_shl_i,
  input  rnd_pkg::exp8_t    i2f_exp8shl_i,
  input  rnd_pkg::exp8_t    i2f_exp8sh0_i,
  input  rnd_pkg::fract32_t i2f_fract32_i,
  output rnd_pkg::float32_t result_o,
  output logic              valid_o,
  output rnd_pkg::fpflags_t flags_o
);

  // decode -> align
  logic              d_sign, d_inv, d_inf, d_snan, d_qnan, d_anan_sign;
  logic              d_carry, d_any_rdy;
  rnd_pkg::fract35_t d_fract;
  rnd_pkg::shamt_t   d_shr, d_shl;
  rnd_pkg::exp10_t   d_exp_shr, d_exp_shl, d_exp_sh0;

  // stage 1
  logic              s1_sign, s1_r, s1_s, s1_valid;
  logic              s1_inv, s1_inf, s1_snan, s1_qnan, s1_anan_sign;
  rnd_pkg::exp10_t   s1_exp;
  rnd_pkg::fract32_t s1_fract;

  // round -> result
  logic [23:0]       r_fract24;
  rnd_pkg::exp10_t   r_exp;
  logic              r_lost;

  rnd_source_decode u_decode (
    .rmode_i, .add_rdy_i, .add_sign_i, .add_sub_0_i, .add_shl_i, .add_exp10shl_i,
    .add_exp10sh0_i, .add_fract28_i, .add_inv_i, .add_inf_i, .add_snan_i, .add_qnan_i,
    .add_anan_sign_i, .mul_rdy_i, .mul_sign_i, .mul_shr_i, .mul_exp10shr_i, .mul_shl_i,
    .mul_exp10shl_i, .mul_exp10sh0_i, .mul_fract28_i, .mul_inv_i, .mul_inf_i,
    .mul_snan_i, .mul_qnan_i, .mul_anan_sign_i, .i2f_rdy_i, .i2f_sign_i, .i2f_shr_i,
    .i2f_exp8shr_i, .i2f_shl_i, .i2f_exp8shl_i, .i2f_exp8sh0_i, .i2f_fract32_i,
    .sign_o(d_sign), .inv_o(d_inv), .inf_o(d_inf), .snan_o(d_snan), .qnan_o(d_qnan),
    .anan_sign_o(d_anan_sign), .fract_o(d_fract), .shr_o(d_shr), .shl_o(d_shl),
    .carry_o(d_carry), .exp_shr_o(d_exp_shr), .exp_shl_o(d_exp_shl),
    .exp_sh0_o(d_exp_sh0), .any_rdy_o(d_any_rdy)
  );

  rnd_align u_align (
    .clk, .rst, .adv_i, .flush_i,
    .sign_i(d_sign), .inv_i(d_inv), .inf_i(d_inf), .snan_i(d_snan), .qnan_i(d_qnan),
    .anan_sign_i(d_anan_sign), .fract_i(d_fract), .shr_i(d_shr), .shl_i(d_shl),
    .carry_i(d_carry), .exp_shr_i(d_exp_shr), .exp_shl_i(d_exp_shl),
    .exp_sh0_i(d_exp_sh0), .any_rdy_i(d_any_rdy),
    .s1_sign_o(s1_sign), .s1_exp_o(s1_exp), .s1_fract_o(s1_fract), .s1_r_o(s1_r),
    .s1_s_o(s1_s), .s1_inv_o(s1_inv), .s1_inf_o(s1_inf), .s1_snan_o(s1_snan),
    .s1_qnan_o(s1_qnan), .s1_anan_sign_o(s1_anan_sign), .s1_valid_o(s1_valid)
  );

  // mode is not pipelined, it applies to the op in stage 1
  rnd_round u_round (
    .rmode_i, .s1_sign_i(s1_sign), .s1_exp_i(s1_exp), .s1_fract_i(s1_fract),
    .s1_r_i(s1_r), .s1_s_i(s1_s),
    .fract24_o(r_fract24), .exp_o(r_exp), .lost_o(r_lost)
  );

  rnd_result u_result (
    .clk, .rst, .adv_i, .flush_i,
    .s1_valid_i(s1_valid), .s1_sign_i(s1_sign), .s1_inv_i(s1_inv), .s1_inf_i(s1_inf),
    .s1_snan_i(s1_snan), .s1_qnan_i(s1_qnan), .s1_anan_sign_i(s1_anan_sign),
    .fract24_i(r_fract24), .exp_i(r_exp), .lost_i(r_lost),
    .result_o, .valid_o, .flags_o
  );

endmodule

// ==== rnd_tb_assert.sv ====
// bound to rnd_top; checks output clearing, stall hold and one-hot ready strobes
module rnd_tb_assert (
  input logic              clk,
  input logic              rst,
  input logic              adv_i,
  input logic              flush_i,
  input logic              add_rdy_i,
  input logic              mul_rdy_i,
  input logic              i2f_rdy_i,
  input rnd_pkg::float32_t result_o,
  input logic              valid_o,
  input rnd_pkg::fpflags_t flags_o
);
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // output register behavior
  ////////////////////////////////////////

  // reset or flush empties the output
  a_clear: assert property (@(posedge clk) (rst || flush_i) |=> !valid_o)
    else $error("valid_o high after reset or flush");

  // stalled pipe keeps its outputs
  a_hold: assert property (@(posedge clk) (!rst && !flush_i && !adv_i) |=>
                           ($stable(result_o) && $stable(valid_o) && $stable(flags_o)))
    else $error("outputs changed while adv_i low");

  // upstream delivers one source at a time
  a_onehot: assert property (@(posedge clk) disable iff (rst)
                             $onehot0({add_rdy_i, mul_rdy_i, i2f_rdy_i}))
    else $error("more than one ready strobe high");

endmodule

bind rnd_top rnd_tb_assert u_rnd_tb_assert (.*);

// ==== rnd_tb.sv ====
// table-driven; rmode_i is not pipelined, so a mode change waits one idle cycle
module rnd_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_ENTRIES      = 22;
  localparam int TIMEOUT_CYCLES = 4 * N_ENTRIES + 50;

  localparam logic [1:0] SRC_ADD = 2'd0;
  localparam logic [1:0] SRC_MUL = 2'd1;
  localparam logic [1:0] SRC_I2F = 2'd2;

  localparam logic [1:0] ACT_NONE  = 2'd0;
  localparam logic [1:0] ACT_FLUSH = 2'd1;  // drop this op with a flush
  localparam logic [1:0] ACT_HOLD  = 2'd2;  // stall with adv_i low

  // spec bits {sign, sub_0, inv, inf, qnan, anan_sign}
  typedef struct packed {
    logic [1:0]        src;
    rnd_pkg::rmode_e   mode;
    logic [5:0]        spec;
    logic [31:0]       fract;  // add/mul use the low 28 bits
    logic [3:0]        shr;    // i2f only
    rnd_pkg::exp10_t   expn;   // sh0 for add/mul, shr candidate for i2f
    logic [1:0]        act;
    rnd_pkg::float32_t res;
    rnd_pkg::fpflags_t flg;
  } entry_t;

  logic clk = 1'b0;
  logic rst;
  logic adv_i, flush_i;
  rnd_pkg::rmode_e   rmode_i;
  logic              add_rdy_i, add_sign_i, add_sub_0_i;
  rnd_pkg::shamt_t   add_shl_i;
  rnd_pkg::exp10_t   add_exp10shl_i, add_exp10sh0_i;
  rnd_pkg::fract28_t add_fract28_i;
  logic              add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i;
  logic              mul_rdy_i, mul_sign_i;
  rnd_pkg::shamt_t   mul_shr_i;
  rnd_pkg::exp10_t   mul_exp10shr_i;
  logic              mul_shl_i;
  rnd_pkg::exp10_t   mul_exp10shl_i, mul_exp10sh0_i;
  rnd_pkg::fract28_t mul_fract28_i;
  logic              mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i, mul_anan_sign_i;
  logic              i2f_rdy_i, i2f_sign_i;
  logic [3:0]        i2f_shr_i;
  rnd_pkg::exp8_t    i2f_exp8shr_i;
  rnd_pkg::shamt_t   i2f_shl_i;
  rnd_pkg::exp8_t    i2f_exp8shl_i, i2f_exp8sh0_i;
  rnd_pkg::fract32_t i2f_fract32_i;
  rnd_pkg::float32_t result_o;
  logic              valid_o;
  rnd_pkg::fpflags_t flags_o;

  entry_t tbl [N_ENTRIES];
  int     pend_idx [$];  // expected ops in output order
  int     pend_due [$];  // adv edge count at which each must show up
  int     adv_cnt = 0;
  logic   adv_last = 1'b0;
  int     cycles = 0;
  int     cur_idx = 0;
  logic   drop_strobe = 1'b0;  // strobe that a flush will kill

  rnd_top u_rnd_top (.*);

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_result(input rnd_pkg::float32_t got, input rnd_pkg::float32_t want,
                              input int idx);
    if (got !== want) begin
      $display("[FAIL] %0t entry %0d result %h, expected %h", $time, idx, got, want);
      $display("TEST RESULT: FAIL");
      $fatal(1, "result mismatch");
    end
  endtask

  task automatic check_flags(input rnd_pkg::fpflags_t got, input rnd_pkg::fpflags_t want,
                             input int idx);
    if (got !== want) begin
      $display("[FAIL] %0t entry %0d flags %h, expected %h", $time, idx, got, want);
      $display("TEST RESULT: FAIL");
      $fatal(1, "flags mismatch");
    end
  endtask

  task automatic stop_with(input string what);
    $display("%s at time %0t", what, $time);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", what);
  endtask

  // counts edges where the pipe moves
  always @(posedge clk) begin
    adv_cnt  <= adv_cnt + (adv_i ? 1 : 0);
    adv_last <= adv_i;
    cycles   <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) stop_with("timeout, pipeline did not drain");
  end

  // sample away from the rising edge
  always @(negedge clk) begin
    int idx;
    int due;
    if (adv_last && valid_o) begin  // fresh output only
      if (pend_idx.size() == 0) stop_with("valid_o with no pending operation");
      idx = pend_idx.pop_front();
      due = pend_due.pop_front();
      if (adv_cnt != due) stop_with("result arrived at the wrong cycle");
      check_result(result_o, tbl[idx].res, idx);
      check_flags(flags_o, tbl[idx].flg, idx);
    end
    if (!rst && adv_i && (add_rdy_i | mul_rdy_i | i2f_rdy_i) && !drop_strobe) begin
      pend_idx.push_back(cur_idx);
      pend_due.push_back(adv_cnt + 2);
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic go_idle();
    add_rdy_i <= 1'b0;
    mul_rdy_i <= 1'b0;
    i2f_rdy_i <= 1'b0;
  endtask

  task automatic drive_entry(input int i);
    entry_t e;
    e = tbl[i];
    rmode_i   <= e.mode;
    add_rdy_i <= (e.src == SRC_ADD);
    mul_rdy_i <= (e.src == SRC_MUL);
    i2f_rdy_i <= (e.src == SRC_I2F);
    add_sign_i      <= e.spec[5];
    add_sub_0_i     <= e.spec[4];
    add_inv_i       <= e.spec[3];
    add_inf_i       <= e.spec[2];
    add_qnan_i      <= e.spec[1];
    add_anan_sign_i <= e.spec[0];
    add_fract28_i   <= e.fract[27:0];
    add_exp10sh0_i  <= e.expn;
    mul_sign_i      <= e.spec[5];
    mul_inv_i       <= e.spec[3];
    mul_inf_i       <= e.spec[2];
    mul_qnan_i      <= e.spec[1];
    mul_anan_sign_i <= e.spec[0];
    mul_fract28_i   <= e.fract[27:0];
    mul_exp10sh0_i  <= e.expn;
    i2f_sign_i      <= e.spec[5];
    i2f_fract32_i   <= e.fract;
    i2f_shr_i       <= e.shr;
    i2f_exp8shr_i   <= e.expn[7:0];
  endtask

  initial begin
    // nearest mode with plain values, ties, mantissa carry, carry bit and inexact
    tbl[0]  = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h0600_0000, 4'd0, 10'd127,
                ACT_NONE, 32'h3fc0_0000, 8'h00};
    tbl[1]  = '{SRC_MUL, rnd_pkg::rm_nearest, 6'b000000, 32'h0400_000c, 4'd0, 10'd128,
                ACT_NONE, 32'h4000_0002, 8'h20};  // odd tie goes up
    tbl[2]  = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h0400_0014, 4'd0, 10'd127,
                ACT_NONE, 32'h3f80_0002, 8'h20};  // even tie stays
    tbl[3]  = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h07ff_fffe, 4'd0, 10'd127,
                ACT_NONE, 32'h4000_0000, 8'h20};
    tbl[4]  = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h0c00_0000, 4'd0, 10'd127,
                ACT_NONE, 32'h4040_0000, 8'h00};  // carry bit set
    tbl[5]  = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h0400_0002, 4'd0, 10'd127,
                ACT_NONE, 32'h3f80_0000, 8'h20};
    // specials
    tbl[6]  = '{SRC_MUL, rnd_pkg::rm_nearest, 6'b100000, 32'h0400_0000, 4'd0, 10'd255,
                ACT_NONE, 32'hff80_0000, 8'ha1};  // overflow
    tbl[7]  = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000100, 32'h0000_0000, 4'd0, 10'd0,
                ACT_NONE, 32'h7f80_0000, 8'h80};
    tbl[8]  = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000011, 32'h0000_0000, 4'd0, 10'd0,
                ACT_NONE, 32'hffc0_0000, 8'h08};
    tbl[9]  = '{SRC_MUL, rnd_pkg::rm_nearest, 6'b001000, 32'h0000_0000, 4'd0, 10'd0,
                ACT_NONE, 32'h7fbf_ffff, 8'h44};
    tbl[10] = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b110000, 32'h0000_0000, 4'd0, 10'd0,
                ACT_NONE, 32'h0000_0000, 8'h10};  // x-x gives +0
    tbl[11] = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h0200_0006, 4'd0, 10'd0,
                ACT_NONE, 32'h0040_0001, 8'h22};  // denormal
    // same inexact value under the other modes
    tbl[12] = '{SRC_ADD, rnd_pkg::rm_to_zero, 6'b100000, 32'h0400_0002, 4'd0, 10'd127,
                ACT_NONE, 32'hbf80_0000, 8'h20};
    tbl[13] = '{SRC_ADD, rnd_pkg::rm_to_infp, 6'b000000, 32'h0400_0002, 4'd0, 10'd127,
                ACT_NONE, 32'h3f80_0001, 8'h20};
    tbl[14] = '{SRC_ADD, rnd_pkg::rm_to_infp, 6'b100000, 32'h0400_0002, 4'd0, 10'd127,
                ACT_NONE, 32'hbf80_0000, 8'h20};
    tbl[15] = '{SRC_I2F, rnd_pkg::rm_to_infp, 6'b000000, 32'h8000_0041, 4'd8, 10'd158,
                ACT_NONE, 32'h4f00_0001, 8'h20};  // only sticky can round this up
    tbl[16] = '{SRC_ADD, rnd_pkg::rm_to_infm, 6'b100000, 32'h0400_0002, 4'd0, 10'd127,
                ACT_NONE, 32'hbf80_0001, 8'h20};
    tbl[17] = '{SRC_ADD, rnd_pkg::rm_to_infm, 6'b000000, 32'h0400_0002, 4'd0, 10'd127,
                ACT_NONE, 32'h3f80_0000, 8'h20};
    tbl[18] = '{SRC_ADD, rnd_pkg::rm_to_infm, 6'b010000, 32'h0000_0000, 4'd0, 10'd0,
                ACT_NONE, 32'h8000_0000, 8'h10};  // x-x gives -0
    // flush and stall
    tbl[19] = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h0600_0000, 4'd0, 10'd128,
                ACT_FLUSH, 32'h4040_0000, 8'h00};
    tbl[20] = '{SRC_MUL, rnd_pkg::rm_nearest, 6'b100000, 32'h0600_0000, 4'd0, 10'd127,
                ACT_HOLD, 32'hbfc0_0000, 8'h00};
    tbl[21] = '{SRC_ADD, rnd_pkg::rm_nearest, 6'b000000, 32'h0400_0000, 4'd0, 10'd127,
                ACT_NONE, 32'h3f80_0000, 8'h00};

    // every input starts defined
    rst     = 1'b1;
    adv_i   = 1'b1;
    flush_i = 1'b0;
    rmode_i = rnd_pkg::rm_nearest;
    {add_rdy_i, add_sign_i, add_sub_0_i, add_shl_i, add_exp10shl_i, add_exp10sh0_i,
     add_fract28_i, add_inv_i, add_inf_i, add_snan_i, add_qnan_i, add_anan_sign_i} = '0;
    {mul_rdy_i, mul_sign_i, mul_shr_i, mul_exp10shr_i, mul_shl_i, mul_exp10shl_i,
     mul_exp10sh0_i, mul_fract28_i, mul_inv_i, mul_inf_i, mul_snan_i, mul_qnan_i,
     mul_anan_sign_i} = '0;
    {i2f_rdy_i, i2f_sign_i, i2f_shr_i, i2f_exp8shr_i, i2f_shl_i, i2f_exp8shl_i,
     i2f_exp8sh0_i, i2f_fract32_i} = '0;

    repeat (8) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_ENTRIES; i++) begin
      if (i > 0 && tbl[i].mode != tbl[i-1].mode) begin
        @(posedge clk);
        go_idle();  // old mode still rounds the op in stage 1
      end
      @(posedge clk);
      drive_entry(i);
      cur_idx = i;
      drop_strobe = (tbl[i].act == ACT_FLUSH);
      if (tbl[i].act == ACT_FLUSH) begin
        @(posedge clk);
        go_idle();
        drop_strobe = 1'b0;
        flush_i <= 1'b1;  // op is in stage 1 now
        @(posedge clk);
        flush_i <= 1'b0;
      end else if (tbl[i].act == ACT_HOLD) begin
        @(posedge clk);
        go_idle();
        adv_i <= 1'b0;
        repeat (3) @(posedge clk);
        adv_i <= 1'b1;
      end
    end
    @(posedge clk);
    go_idle();

    while (pend_idx.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== build.f ====
rnd_pkg.sv
rnd_source_decode.sv
rnd_align.sv
rnd_round.sv
rnd_result.sv
rnd_top.sv
rnd_tb_assert.sv
rnd_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds and runs the testbench with Verilator; exit status follows the simulation
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rnd_tb -f build.f -o rnd_sim \
  && ./obj_dir/rnd_sim \
  || { echo "simulation failed"; exit 1; }
